// File: iu.f
+incdir+.
iu_pkg.sv
iu_alu.sv
iu_mul.sv
iu_div.sv
iu_ctrl.sv
iu_top.sv
tb_iu_top.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wall
TOP       ?= tb_iu_top
FILELIST  ?= iu.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

# The simulator exits non-zero on $fatal, which fails this target
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: tb_iu_tasks.svh
// Integer execution unit testbench tasks
// Reference model, LCG operands, stream driver with in-order checking, tests

`ifndef TB_IU_TASKS_SVH
`define TB_IU_TASKS_SVH

logic [31:0] lcg_state = 32'd21872;
logic [5:0]  next_preg = '0;
iu_issue_t   iss_q[$];
iu_wb_t      exp_q[$];

logic [31:0] corners [6] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                             32'h7fff_ffff, 32'h8000_0000, 32'h0000_0013};
iu_op_e alu_ops [10] = '{op_add, op_sub, op_and, op_or, op_xor,
                         op_sll, op_srl, op_sra, op_slt, op_sltu};
iu_op_e mul_ops [4] = '{op_mul, op_mulh, op_mulhsu, op_mulhu};
iu_op_e div_ops [4] = '{op_div, op_divu, op_rem, op_remu};

function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// RV32 semantics, including the divide-by-zero and overflow rules
function automatic logic [31:0] model(input iu_op_e op, input logic [31:0] a,
                                      input logic [31:0] b);
  logic [63:0] pa;
  logic [63:0] pb;
  logic [63:0] p;
  logic        zero;
  logic        ovf;
  logic [31:0] r;
  pa   = (op == op_mulhu) ? {32'b0, a} : {{32{a[31]}}, a};
  pb   = (op == op_mulh) ? {{32{b[31]}}, b} : {32'b0, b};
  p    = pa * pb;
  zero = (b == '0);
  ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  case (op)
    op_add:    r = a + b;
    op_sub:    r = a - b;
    op_and:    r = a & b;
    op_or:     r = a | b;
    op_xor:    r = a ^ b;
    op_sll:    r = a << b[4:0];
    op_srl:    r = a >> b[4:0];
    op_sra:    r = $signed(a) >>> b[4:0];
    op_slt:    r = {31'b0, $signed(a) < $signed(b)};
    op_sltu:   r = {31'b0, a < b};
    op_mul:    r = p[31:0];
    op_mulh, op_mulhsu, op_mulhu: r = p[63:32];
    op_div:    r = zero ? '1 : ovf ? a : $unsigned($signed(a) / $signed(b));
    op_divu:   r = zero ? '1 : a / b;
    op_rem:    r = zero ? a : ovf ? '0 : $unsigned($signed(a) % $signed(b));
    op_remu:   r = zero ? a : a % b;
    default:   r = '0;
  endcase
  return r;
endfunction

function automatic bit is_div_op(input iu_op_e op);
  return op inside {op_div, op_divu, op_rem, op_remu};
endfunction

function automatic iu_op_e rand_op();
  logic [31:0] r;
  r = (next_rand() >> 8) % 32'd14;
  if (r < 32'd10) return alu_ops[r[3:0]];
  return mul_ops[r[1:0]];
endfunction

task automatic queue_op(input iu_op_e op, input logic [31:0] a, input logic [31:0] b);
  iu_issue_t req;
  iu_wb_t    exp_wb;
  req.op        = op;
  req.src0      = a;
  req.src1      = b;
  req.dst_preg  = next_preg;
  exp_wb.preg   = next_preg;
  exp_wb.data   = model(op, a, b);
  iss_q.push_back(req);
  exp_q.push_back(exp_wb);
  next_preg = next_preg + 6'd1;
endtask

task automatic drive_inputs(input bit rand_ready);
  iss_valid = (iss_q.size() > 0);
  if (iss_valid) iss_req = iss_q[0];
  wb_ready = rand_ready ? (next_rand() > 32'h5000_0000) : 1'b1;
endtask

// Issues the queued ops and checks every writeback in order
task automatic run_stream(input string name, input bit rand_ready);
  iu_wb_t held;
  iu_wb_t exp_wb;
  bit     held_vld;
  bit     div_pend;
  bit     fast_prev;
  bit     acc;
  held      = '0;
  held_vld  = 1'b0;
  div_pend  = 1'b0;
  fast_prev = 1'b0;
  @(posedge forever_cpuclk);
  #1;
  drive_inputs(rand_ready);
  while (exp_q.size() > 0) begin
    @(negedge forever_cpuclk);
    assert (!fast_prev || wb_valid)
      else stop_on_error($sformatf("no writeback one cycle after issue in %s", name));
    assert (!div_pend || !iss_ready)
      else stop_on_error($sformatf("iss_ready high while a divide is pending in %s", name));
    if (held_vld) begin
      assert (wb_valid && wb == held) else stop_on_error($sformatf(
        "mismatch %s held payload expected %h actual %h", name, held, wb));
    end
    held_vld = 1'b0;
    if (wb_valid && wb_ready) begin
      exp_wb = exp_q.pop_front();
      assert (wb == exp_wb) else stop_on_error($sformatf(
        "mismatch %s expected preg %0d data %h actual preg %0d data %h",
        name, exp_wb.preg, exp_wb.data, wb.preg, wb.data));
      div_pend = 1'b0;
    end else if (wb_valid) begin
      held     = wb;
      held_vld = 1'b1;
    end
    acc       = iss_valid && iss_ready;
    fast_prev = acc && !is_div_op(iss_req.op);
    if (acc) begin
      div_pend = is_div_op(iss_req.op);
      iss_q.delete(0);
    end
    @(posedge forever_cpuclk);
    #1;
    drive_inputs(rand_ready);
  end
  iss_valid = 1'b0;
  wb_ready  = 1'b1;
endtask

task automatic test_reset();
  @(negedge forever_cpuclk);
  assert (!wb_valid) else stop_on_error("wb_valid high after reset");
  assert (iss_ready) else stop_on_error("iss_ready low after reset");
endtask

// Corner grid plus random pairs, some with a short divisor
task automatic fill_ops(input iu_op_e op, input int n_rand);
  logic [31:0] a;
  logic [31:0] b;
  foreach (corners[i]) begin
    foreach (corners[j]) begin
      queue_op(op, corners[i], corners[j]);
    end
  end
  repeat (n_rand) begin
    a = next_rand();
    b = next_rand();
    if (b[31]) b = b >> 12;
    queue_op(op, a, b);
  end
endtask

task automatic test_alu();
  foreach (alu_ops[k]) fill_ops(alu_ops[k], 20);
  run_stream("alu", 1'b0);
endtask

task automatic test_mul();
  foreach (mul_ops[k]) fill_ops(mul_ops[k], 20);
  run_stream("mul", 1'b0);
endtask

task automatic test_div();
  foreach (div_ops[k]) fill_ops(div_ops[k], 20);
  run_stream("div", 1'b0);
endtask

task automatic test_mixed();
  iu_op_e      op;
  logic [31:0] a;
  logic [31:0] b;
  repeat (200) begin
    op = rand_op();
    a  = next_rand();
    b  = next_rand();
    queue_op(op, a, b);
  end
  run_stream("mixed", 1'b1);
endtask

task automatic test_flush();
  @(posedge forever_cpuclk);
  #1;
  iss_req.op       = op_div;
  iss_req.src0     = 32'd100000;
  iss_req.src1     = 32'd7;
  iss_req.dst_preg = 6'd33;
  iss_valid        = 1'b1;
  @(negedge forever_cpuclk);
  assert (iss_ready) else stop_on_error("divide not accepted before flush");
  @(posedge forever_cpuclk);
  #1;
  iss_valid = 1'b0;
  repeat (4) begin
    @(negedge forever_cpuclk);
    assert (!wb_valid && !iss_ready) else stop_on_error("divide not pending before flush");
  end
  @(posedge forever_cpuclk);
  #1;
  flush = 1'b1;
  @(posedge forever_cpuclk);
  #1;
  flush = 1'b0;
  // Longer than a whole divide
  repeat (40) begin
    @(negedge forever_cpuclk);
    assert (!wb_valid) else stop_on_error("writeback from a flushed divide");
  end
  // Unit idle here so only flush can close issue
  @(posedge forever_cpuclk);
  #1;
  flush = 1'b1;
  @(negedge forever_cpuclk);
  assert (!iss_ready) else stop_on_error("iss_ready high during flush");
  @(posedge forever_cpuclk);
  #1;
  flush = 1'b0;
  queue_op(op_add, 32'd100000, 32'd7);
  run_stream("flush", 1'b0);
endtask

`endif

// File: tb_iu_top.sv
// Testbench for the integer execution unit
// Directed ALU, multiplier, divider, back-pressure and flush tests

`timescale 1ns/100ps

module tb_iu_top;

  import iu_pkg::*;

  // Full sequence needs roughly 9500 cycles, mostly divides
  localparam int max_cycles = 20000;

  logic      forever_cpuclk;
  logic      arst_n;
  logic      iss_valid;
  logic      iss_ready;
  iu_issue_t iss_req;
  logic      wb_valid;
  logic      wb_ready;
  iu_wb_t    wb;
  logic      flush;
  int        cycle_cnt = 0;

  iu_top DUT (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n        ),
    .iss_valid      (iss_valid     ),
    .iss_ready      (iss_ready     ),
    .iss_req        (iss_req       ),
    .wb_valid       (wb_valid      ),
    .wb_ready       (wb_ready      ),
    .wb             (wb            ),
    .flush          (flush         )
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  initial begin
    forever_cpuclk = 1'b0;
    forever begin
      #5 forever_cpuclk = ~forever_cpuclk;
    end
  end

  always @(posedge forever_cpuclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      stop_on_error($sformatf("timeout, run still going after %0d cycles", cycle_cnt));
    end
  end

  `include "tb_iu_tasks.svh"

  initial begin
    arst_n    = 1'b0;
    iss_valid = 1'b0;
    iss_req   = '0;
    wb_ready  = 1'b1;
    flush     = 1'b0;
    repeat (16) @(posedge forever_cpuclk);
    #1;
    arst_n = 1'b1;
    test_reset();
    test_alu();
    test_mul();
    test_div();
    test_mixed();
    test_flush();
    $display("No errors");
    $finish;
  end

endmodule

// File: iu_top.sv
// Integer execution unit top
// Control with ALU, multiplier and divider around it

`timescale 1ns/100ps

module iu_top (
  input  logic              forever_cpuclk,
  input  logic              arst_n,
  input  logic              iss_valid,
  output logic              iss_ready,
  input  iu_pkg::iu_issue_t iss_req,
  output logic              wb_valid,
  input  logic              wb_ready,
  output iu_pkg::iu_wb_t    wb,
  input  logic              flush
);

  import iu_pkg::*;

  logic            alu_en;
  logic            mul_en;
  logic            div_start;
  logic            div_kill;
  logic            div_ack;
  logic            div_busy;
  logic            div_rslt_vld;
  logic [xlen-1:0] alu_rslt;
  logic [xlen-1:0] mul_rslt;
  logic [xlen-1:0] div_rslt;

  iu_ctrl x_iu_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n        ),
    .iss_valid      (iss_valid     ),
    .iss_ready      (iss_ready     ),
    .iss_req        (iss_req       ),
    .wb_valid       (wb_valid      ),
    .wb_ready       (wb_ready      ),
    .wb             (wb            ),
    .flush          (flush         ),
    .alu_rslt       (alu_rslt      ),
    .mul_rslt       (mul_rslt      ),
    .div_busy       (div_busy      ),
    .div_rslt_vld   (div_rslt_vld  ),
    .div_rslt       (div_rslt      ),
    .alu_en         (alu_en        ),
    .mul_en         (mul_en        ),
    .div_start      (div_start     ),
    .div_kill       (div_kill      ),
    .div_ack        (div_ack       )
  );

  iu_alu x_iu_alu (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n        ),
    .alu_en         (alu_en        ),
    .op             (iss_req.op    ),
    .src0           (iss_req.src0  ),
    .src1           (iss_req.src1  ),
    .rslt           (alu_rslt      )
  );

  iu_mul x_iu_mul (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n        ),
    .mul_en         (mul_en        ),
    .op             (iss_req.op    ),
    .src0           (iss_req.src0  ),
    .src1           (iss_req.src1  ),
    .rslt           (mul_rslt      )
  );

  iu_div x_iu_div (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n        ),
    .div_start      (div_start     ),
    .div_kill       (div_kill      ),
    .div_ack        (div_ack       ),
    .op             (iss_req.op    ),
    .src0           (iss_req.src0  ),
    .src1           (iss_req.src1  ),
    .busy           (div_busy      ),
    .rslt_vld       (div_rslt_vld  ),
    .rslt           (div_rslt      )
  );

endmodule

// File: iu_ctrl.sv
// Integer unit control
// Issue handshake and stall, EX2 tracking, in-order writeback select and flush

`timescale 1ns/100ps

module iu_ctrl (
  input  logic                   forever_cpuclk,
  input  logic                   arst_n,
  input  logic                   iss_valid,
  output logic                   iss_ready,
  input  iu_pkg::iu_issue_t      iss_req,
  output logic                   wb_valid,
  input  logic                   wb_ready,
  output iu_pkg::iu_wb_t         wb,
  input  logic                   flush,
  input  logic [iu_pkg::xlen-1:0] alu_rslt,
  input  logic [iu_pkg::xlen-1:0] mul_rslt,
  input  logic                   div_busy,
  input  logic                   div_rslt_vld,
  input  logic [iu_pkg::xlen-1:0] div_rslt,
  output logic                   alu_en,
  output logic                   mul_en,
  output logic                   div_start,
  output logic                   div_kill,
  output logic                   div_ack
);

  import iu_pkg::*;

  typedef enum logic {
    unit_alu,
    unit_mul
  } unit_e;

  logic              accept;
  logic [4:0]        op_code;
  logic              is_alu;
  logic              is_mul;
  logic              is_div;
  logic              ex2_vld_q;
  unit_e             ex2_unit_q;
  logic [preg_w-1:0] ex2_preg_q;
  logic              div_pend_q;
  logic [preg_w-1:0] div_preg_q;
  logic              wb_fire;
  logic              div_wb;

  // Group decode from the upper op bits
  assign op_code = iss_req.op;
  assign is_alu  = ~op_code[4];
  assign is_mul  = (op_code[4:3] == 2'b10);
  assign is_div  = (op_code[4:3] == 2'b11);

  // EX2 must be empty or leaving, and no divide outstanding
  assign iss_ready = (!ex2_vld_q || wb_ready) && !div_pend_q && !flush;
  assign accept    = iss_valid && iss_ready;

  assign alu_en    = accept && is_alu;
  assign mul_en    = accept && is_mul;
  assign div_start = accept && is_div;
  assign div_kill  = flush;

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      ex2_vld_q  <= 1'b0;
      div_pend_q <= 1'b0;
    end else if (flush) begin
      ex2_vld_q  <= 1'b0;
      div_pend_q <= 1'b0;
    end else begin
      if (alu_en || mul_en) begin
        ex2_vld_q <= 1'b1;
      end else if (wb_fire && ex2_vld_q) begin
        ex2_vld_q <= 1'b0;
      end
      if (div_start) begin
        div_pend_q <= 1'b1;
      end else if (div_ack) begin
        div_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (alu_en || mul_en) begin
      ex2_unit_q <= mul_en ? unit_mul : unit_alu;
      ex2_preg_q <= iss_req.dst_preg;
    end
    if (div_start) begin
      div_preg_q <= iss_req.dst_preg;
    end
  end

  // A divide only completes with EX2 empty
  assign div_wb   = !ex2_vld_q && div_pend_q && div_rslt_vld;
  assign wb_valid = ex2_vld_q || div_wb;
  assign wb_fire  = wb_valid && wb_ready;
  assign div_ack  = div_wb && wb_ready;

  always_comb begin
    if (ex2_vld_q) begin
      wb.preg = ex2_preg_q;
      wb.data = (ex2_unit_q == unit_mul) ? mul_rslt : alu_rslt;
    end else begin
      wb.preg = div_preg_q;
      wb.data = div_rslt;
    end
  end

  a_wb_stable: assert property (
    @(posedge forever_cpuclk) disable iff (!arst_n)
    wb_valid && !wb_ready && !flush |=> wb_valid && $stable(wb)
  );

  a_div_blocks_issue: assert property (
    @(posedge forever_cpuclk) disable iff (!arst_n)
    div_busy |-> !iss_ready
  );

endmodule

// File: iu_div.sv
// Integer divider
// Restoring shift-subtract on magnitudes, 32 iterations plus a sign fix cycle,
// result held until acknowledged

`timescale 1ns/100ps

module iu_div (
  input  logic                   forever_cpuclk,
  input  logic                   arst_n,
  input  logic                   div_start,
  input  logic                   div_kill,
  input  logic                   div_ack,
  input  iu_pkg::iu_op_e         op,
  input  logic [iu_pkg::xlen-1:0] src0,
  input  logic [iu_pkg::xlen-1:0] src1,
  output logic                   busy,
  output logic                   rslt_vld,
  output logic [iu_pkg::xlen-1:0] rslt
);

  import iu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_fix,
    st_done
  } div_st_e;

  div_st_e              state_q;
  logic [div_cnt_w-1:0] cnt_q;
  logic [xlen-1:0]      quo_q;
  logic [xlen-1:0]      rem_q;
  logic [xlen-1:0]      dvsr_q;
  logic [xlen-1:0]      rslt_q;
  logic                 is_rem_q;
  logic                 q_neg_q;
  logic                 r_neg_q;
  logic                 zero_q;
  logic                 sgn_op;
  logic [xlen-1:0]      a_mag;
  logic [xlen-1:0]      b_mag;
  logic [xlen:0]        trial;
  logic [xlen-1:0]      q_fix;
  logic [xlen-1:0]      r_fix;

  assign sgn_op = (op == op_div) || (op == op_rem);
  assign a_mag  = (sgn_op && src0[xlen-1]) ? -src0 : src0;
  assign b_mag  = (sgn_op && src1[xlen-1]) ? -src1 : src1;

  // Borrow in bit xlen means the divisor does not fit
  assign trial = {rem_q, quo_q[xlen-1]} - {1'b0, dvsr_q};

  // Divide by zero leaves all ones in quo_q and |dividend| in rem_q,
  // so only the quotient sign needs overriding.
  // Overflow (min / -1) falls out of the magnitude path unchanged
  assign q_fix = zero_q ? '1 : (q_neg_q ? -quo_q : quo_q);
  assign r_fix = r_neg_q ? -rem_q : rem_q;

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else if (div_kill) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: if (div_start) begin
          state_q <= st_run;
          cnt_q   <= '0;
        end
        st_run: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == div_cnt_w'(xlen - 1)) begin
            state_q <= st_fix;
          end
        end
        st_fix:  state_q <= st_done;
        st_done: if (div_ack) state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (state_q == st_idle && div_start) begin
      quo_q    <= a_mag;
      rem_q    <= '0;
      dvsr_q   <= b_mag;
      is_rem_q <= (op == op_rem) || (op == op_remu);
      q_neg_q  <= sgn_op && (src0[xlen-1] ^ src1[xlen-1]);
      r_neg_q  <= sgn_op && src0[xlen-1];
      zero_q   <= (src1 == '0);
    end else if (state_q == st_run) begin
      quo_q <= {quo_q[xlen-2:0], ~trial[xlen]};
      rem_q <= trial[xlen] ? {rem_q[xlen-2:0], quo_q[xlen-1]} : trial[xlen-1:0];
    end else if (state_q == st_fix) begin
      rslt_q <= is_rem_q ? r_fix : q_fix;
    end
  end

  assign busy     = (state_q != st_idle);
  assign rslt_vld = (state_q == st_done);
  assign rslt     = rslt_q;

  // Control keeps issue closed for the whole divide
  a_no_start_busy: assert property (
    @(posedge forever_cpuclk) disable iff (!arst_n)
    div_start |-> !busy
  );

endmodule

// File: iu_mul.sv
// Integer multiplier
// Stage one registers four 16x16 partial products of the operand magnitudes,
// stage two sums them and restores the sign

`timescale 1ns/100ps

module iu_mul (
  input  logic                   forever_cpuclk,
  input  logic                   arst_n,
  input  logic                   mul_en,
  input  iu_pkg::iu_op_e         op,
  input  logic [iu_pkg::xlen-1:0] src0,
  input  logic [iu_pkg::xlen-1:0] src1,
  output logic [iu_pkg::xlen-1:0] rslt
);

  import iu_pkg::*;

  typedef struct packed {
    logic [31:0] ll;
    logic [31:0] lh;
    logic [31:0] hl;
    logic [31:0] hh;
  } mul_pp_t;

  logic            a_sgn;
  logic            b_sgn;
  logic            a_neg;
  logic            b_neg;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;
  mul_pp_t         pp_d;
  mul_pp_t         pp_q;
  logic            neg_q;
  logic            hi_q;
  logic [63:0]     prod_mag;
  logic [63:0]     prod;

  // mulhsu treats only src0 as signed
  assign a_sgn = (op == op_mulh) || (op == op_mulhsu);
  assign b_sgn = (op == op_mulh);
  assign a_neg = a_sgn & src0[xlen-1];
  assign b_neg = b_sgn & src1[xlen-1];
  assign a_mag = a_neg ? -src0 : src0;
  assign b_mag = b_neg ? -src1 : src1;

  assign pp_d.ll = a_mag[15:0]  * b_mag[15:0];
  assign pp_d.lh = a_mag[15:0]  * b_mag[31:16];
  assign pp_d.hl = a_mag[31:16] * b_mag[15:0];
  assign pp_d.hh = a_mag[31:16] * b_mag[31:16];

  always_ff @(posedge forever_cpuclk) begin
    if (mul_en) begin
      pp_q <= pp_d;
    end
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      neg_q <= 1'b0;
      hi_q  <= 1'b0;
    end else if (mul_en) begin
      neg_q <= a_neg ^ b_neg;
      hi_q  <= (op != op_mul);
    end
  end

  // EX2 sum
  assign prod_mag = {pp_q.hh, pp_q.ll}
                  + ({32'b0, pp_q.lh} << 16)
                  + ({32'b0, pp_q.hl} << 16);
  assign prod     = neg_q ? -prod_mag : prod_mag;
  assign rslt     = hi_q ? prod[63:32] : prod[31:0];

endmodule

// File: iu_alu.sv
// Integer ALU
// Single-cycle add/sub, logic, shift and compare with an EX2 result register

`timescale 1ns/100ps

module iu_alu (
  input  logic                   forever_cpuclk,
  input  logic                   arst_n,
  input  logic                   alu_en,
  input  iu_pkg::iu_op_e         op,
  input  logic [iu_pkg::xlen-1:0] src0,
  input  logic [iu_pkg::xlen-1:0] src1,
  output logic [iu_pkg::xlen-1:0] rslt
);

  import iu_pkg::*;

  logic [4:0]      shamt;
  logic [xlen-1:0] alu_val;
  logic [xlen-1:0] rslt_q;

  assign shamt = src1[4:0];

  always_comb begin
    alu_val = '0;
    case (op)
      op_add:  alu_val = src0 + src1;
      op_sub:  alu_val = src0 - src1;
      op_and:  alu_val = src0 & src1;
      op_or:   alu_val = src0 | src1;
      op_xor:  alu_val = src0 ^ src1;
      op_sll:  alu_val = src0 << shamt;
      op_srl:  alu_val = src0 >> shamt;
      op_sra:  alu_val = $signed(src0) >>> shamt;
      op_slt:  alu_val = {{(xlen-1){1'b0}}, $signed(src0) < $signed(src1)};
      op_sltu: alu_val = {{(xlen-1){1'b0}}, src0 < src1};
      default: alu_val = '0;
    endcase
  end

  // EX2 result, held while no new ALU op is accepted
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      rslt_q <= '0;
    end else if (alu_en) begin
      rslt_q <= alu_val;
    end
  end

  assign rslt = rslt_q;

endmodule

// File: iu_pkg.sv
// Integer execution unit shared definitions
// Widths, op codes and the issue and writeback words

package iu_pkg;

  localparam int xlen      = 32;
  localparam int preg_w    = 6;
  localparam int div_cnt_w = 6;

  // Bits 4..3 give the unit group
  // 0x00-0x09 ALU, 0x10-0x13 MUL, 0x18-0x1b DIV
  typedef enum logic [4:0] {
    op_add    = 5'h00,
    op_sub    = 5'h01,
    op_and    = 5'h02,
    op_or     = 5'h03,
    op_xor    = 5'h04,
    op_sll    = 5'h05,
    op_srl    = 5'h06,
    op_sra    = 5'h07,
    op_slt    = 5'h08,
    op_sltu   = 5'h09,
    op_mul    = 5'h10,
    op_mulh   = 5'h11,
    op_mulhsu = 5'h12,
    op_mulhu  = 5'h13,
    op_div    = 5'h18,
    op_divu   = 5'h19,
    op_rem    = 5'h1a,
    op_remu   = 5'h1b
  } iu_op_e;

  // 75 bits
  typedef struct packed {
    iu_op_e              op;
    logic [xlen-1:0]     src0;
    logic [xlen-1:0]     src1;
    logic [preg_w-1:0]   dst_preg;
  } iu_issue_t;

  // 38 bits
  typedef struct packed {
    logic [preg_w-1:0]   preg;
    logic [xlen-1:0]     data;
  } iu_wb_t;

endpackage
